// ==== src/pad_pkg.sv ====
////////////////////
// Pad counts and indices are fixed by the board wiring
// Every pad-side and core-side bus uses pad_bus_t
////////////////////

package pad_pkg;

  ////////////////////
  // Pad counts
  ////////////////////

  // Muxed pads, GPIO style
  localparam int unsigned NumMio = 20;
  // Dedicated pads, SPI device and friends
  localparam int unsigned NumDio = 8;

  ////////////////////
  // Muxed pad indices
  ////////////////////

  // Side-channel capture trigger output
  localparam int unsigned MioTrigger = 15;
  // Strap, high selects JTAG over SPI
  localparam int unsigned MioJtagEn  = 16;
  // JTAG resets, both active low
  localparam int unsigned MioTrst    = 18;
  localparam int unsigned MioSrst    = 19;

  ////////////////////
  // Dedicated pad indices
  ////////////////////

  // SPI device pins, shared with the debug port
  localparam int unsigned DioSpiSck = 0;
  localparam int unsigned DioSpiCsb = 1;
  localparam int unsigned DioSpiSdi = 2;
  localparam int unsigned DioSpiSdo = 3;

  ////////////////////
  // Pad bus types
  ////////////////////

  typedef logic [NumMio-1:0] mio_vec_t;
  typedef logic [NumDio-1:0] dio_vec_t;

  // Dedicated pads sit in the upper bits
  typedef struct packed {
    dio_vec_t dio;
    mio_vec_t mio;
  } pad_bus_t;

endpackage : pad_pkg

// ==== src/jtag_pkg.sv ====
////////////////////
// JTAG request toward the core and its idle value
// Borrowed pads show CoreTieOff to the core while JTAG owns them
////////////////////

package jtag_pkg;

  // Request toward the core debug module
  typedef struct packed {
    logic tck;
    logic tms;
    logic tdi;
    logic trst_n;
    logic srst_n;
  } jtag_req_t;

  // JTAG off, clocks low and both resets released
  localparam jtag_req_t JtagReqIdle = '{
    tck:    1'b0,
    tms:    1'b0,
    tdi:    1'b0,
    trst_n: 1'b1,
    srst_n: 1'b1
  };

  // SPI chip select is active low, so it idles high
  localparam pad_pkg::pad_bus_t CoreTieOff = '{
    dio: pad_pkg::dio_vec_t'(1) << pad_pkg::DioSpiCsb,
    mio: '0
  };

endpackage : jtag_pkg

// ==== src/pad_in_sync.sv ====
////////////////////
// Two-flop synchronizer over the whole pad bus, cleared on reset
// JTAG pins are sampled here too, so TCK must run well below clk_main
////////////////////

`timescale 1ns/1ps

module pad_in_sync (
  input  logic              clk_main_i,
  input  logic              rst_n_i,
  // Raw board pins
  input  pad_pkg::pad_bus_t pad_in_i,
  // Pins in the clk_main domain
  output pad_pkg::pad_bus_t pad_sync_o
);

  import pad_pkg::*;

  // First stage may go metastable
  pad_bus_t sync_q1;
  // Second stage is safe to use
  pad_bus_t sync_q2;

  ////////////////////
  // Sync stages
  ////////////////////

  always_ff @(posedge clk_main_i) begin
    if (!rst_n_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= pad_in_i;
      sync_q2 <= sync_q1;
    end
  end

  // Strap reads 0 out of reset, JTAG stays off until it is seen
  assign pad_sync_o = sync_q2;

endmodule : pad_in_sync

// ==== src/jtag_overlay_mux.sv ====
////////////////////
// Strap high hands four SPI pads and two muxed pads to the debug port
// Purely combinational, strap is decoded from the synchronized bus
////////////////////

`timescale 1ns/1ps

module jtag_overlay_mux (
  // Synchronized pad inputs
  input  pad_pkg::pad_bus_t   pad_sync_i,
  // Core drive toward the pads
  input  pad_pkg::pad_bus_t   core_out_i,
  input  pad_pkg::pad_bus_t   core_oe_i,
  // Debug port data out
  input  logic                jtag_tdo_i,
  // Pad inputs as the core sees them
  output pad_pkg::pad_bus_t   core_in_o,
  // Request toward the debug port
  output jtag_pkg::jtag_req_t jtag_o,
  // Merged drive toward the output stage
  output pad_pkg::pad_bus_t   fab_out_o,
  output pad_pkg::pad_bus_t   fab_oe_o
);

  import pad_pkg::*;
  import jtag_pkg::*;

  logic jtag_en;

  // Strap, polarity high
  assign jtag_en = pad_sync_i.mio[MioJtagEn];

  ////////////////////
  // Input direction
  ////////////////////

  always_comb begin
    core_in_o = pad_sync_i;
    jtag_o    = JtagReqIdle;

    if (jtag_en) begin
      // Debug port takes the SPI clock, select and data in
      jtag_o.tck    = pad_sync_i.dio[DioSpiSck];
      jtag_o.tms    = pad_sync_i.dio[DioSpiCsb];
      jtag_o.tdi    = pad_sync_i.dio[DioSpiSdi];
      jtag_o.trst_n = pad_sync_i.mio[MioTrst];
      jtag_o.srst_n = pad_sync_i.mio[MioSrst];

      // Core only sees the tie-off on borrowed pads
      core_in_o.dio[DioSpiSck] = CoreTieOff.dio[DioSpiSck];
      core_in_o.dio[DioSpiCsb] = CoreTieOff.dio[DioSpiCsb];
      core_in_o.dio[DioSpiSdi] = CoreTieOff.dio[DioSpiSdi];
      core_in_o.mio[MioTrst]   = CoreTieOff.mio[MioTrst];
      core_in_o.mio[MioSrst]   = CoreTieOff.mio[MioSrst];
    end
  end

  ////////////////////
  // Output direction
  ////////////////////

  always_comb begin
    fab_out_o = core_out_i;
    fab_oe_o  = core_oe_i;

    if (jtag_en) begin
      // TDO replaces SPI data out and is always driven
      fab_out_o.dio[DioSpiSdo] = jtag_tdo_i;
      fab_oe_o.dio[DioSpiSdo]  = 1'b1;

      // Pads that now act as JTAG inputs are never driven
      fab_oe_o.dio[DioSpiSck] = 1'b0;
      fab_oe_o.dio[DioSpiCsb] = 1'b0;
      fab_oe_o.dio[DioSpiSdi] = 1'b0;
      fab_oe_o.mio[MioTrst]   = 1'b0;
      fab_oe_o.mio[MioSrst]   = 1'b0;
    end
  end

endmodule : jtag_overlay_mux

// ==== src/pad_out_stage.sv ====
////////////////////
// Registered pad drive with per-pad inversion, one cycle of latency
// Capture trigger only passes while the crypto engine is busy
////////////////////

`timescale 1ns/1ps

module pad_out_stage (
  input  logic              clk_main_i,
  input  logic              rst_n_i,
  // Merged drive from the overlay mux
  input  pad_pkg::pad_bus_t fab_out_i,
  input  pad_pkg::pad_bus_t fab_oe_i,
  // One invert bit per pad
  input  pad_pkg::pad_bus_t pad_attr_i,
  // Crypto engine idle flag
  input  logic              aes_idle_i,
  // Toward the pads
  output pad_pkg::pad_bus_t pad_out_o,
  output pad_pkg::pad_bus_t pad_oe_o
);

  import pad_pkg::*;

  pad_bus_t out_d;
  pad_bus_t out_q;
  pad_bus_t oe_q;
  logic     trigger_gated;

  ////////////////////
  // Trigger gate
  ////////////////////

  // Only forward the trigger while the engine works
  assign trigger_gated = fab_out_i.mio[MioTrigger] & ~aes_idle_i;

  ////////////////////
  // Inversion
  ////////////////////

  always_comb begin
    out_d.mio = fab_out_i.mio ^ pad_attr_i.mio;
    out_d.dio = fab_out_i.dio ^ pad_attr_i.dio;
    // Gate first, invert afterwards
    out_d.mio[MioTrigger] = trigger_gated ^ pad_attr_i.mio[MioTrigger];
  end

  ////////////////////
  // Output flops
  ////////////////////

  // Keeps the trigger edge on a clock edge
  always_ff @(posedge clk_main_i) begin
    if (!rst_n_i) begin
      out_q <= '0;
      oe_q  <= '0;
    end else begin
      out_q <= out_d;
      oe_q  <= fab_oe_i;
    end
  end

  assign pad_out_o = out_q;
  // Enables are never inverted
  assign pad_oe_o  = oe_q;

endmodule : pad_out_stage

// ==== src/io_fabric_top.sv ====
////////////////////
// Pad fabric between board pins and core, single clock clk_main
// In path 2 cycles, out path 1 cycle, no handshake
////////////////////

`timescale 1ns/1ps

module io_fabric_top (
  input  logic                clk_main_i,
  input  logic                rst_n_i,
  // Pad side
  input  pad_pkg::pad_bus_t   pad_in_i,
  output pad_pkg::pad_bus_t   pad_out_o,
  output pad_pkg::pad_bus_t   pad_oe_o,
  // Core side
  input  pad_pkg::pad_bus_t   core_out_i,
  input  pad_pkg::pad_bus_t   core_oe_i,
  input  pad_pkg::pad_bus_t   pad_attr_i,
  input  logic                aes_idle_i,
  output pad_pkg::pad_bus_t   core_in_o,
  // Debug port
  output jtag_pkg::jtag_req_t jtag_o,
  input  logic                jtag_tdo_i
);

  import pad_pkg::*;

  pad_bus_t pad_in_sync;
  pad_bus_t fab_out;
  pad_bus_t fab_oe;

  ////////////////////
  // Input sync
  ////////////////////

  pad_in_sync u_in_sync (
    .clk_main_i ( clk_main_i  ),
    .rst_n_i    ( rst_n_i     ),
    .pad_in_i   ( pad_in_i    ),
    .pad_sync_o ( pad_in_sync )
  );

  ////////////////////
  // JTAG overlay
  ////////////////////

  jtag_overlay_mux u_jtag_mux (
    .pad_sync_i ( pad_in_sync ),
    .core_out_i ( core_out_i  ),
    .core_oe_i  ( core_oe_i   ),
    .jtag_tdo_i ( jtag_tdo_i  ),
    .core_in_o  ( core_in_o   ),
    .jtag_o     ( jtag_o      ),
    .fab_out_o  ( fab_out     ),
    .fab_oe_o   ( fab_oe      )
  );

  ////////////////////
  // Output stage
  ////////////////////

  pad_out_stage u_out_stage (
    .clk_main_i ( clk_main_i ),
    .rst_n_i    ( rst_n_i    ),
    .fab_out_i  ( fab_out    ),
    .fab_oe_i   ( fab_oe     ),
    .pad_attr_i ( pad_attr_i ),
    .aes_idle_i ( aes_idle_i ),
    .pad_out_o  ( pad_out_o  ),
    .pad_oe_o   ( pad_oe_o   )
  );

endmodule : io_fabric_top

// ==== sim/io_fabric_tb.sv ====
////////////////////
// Vectors come from sim/io_vectors_input.txt relative to the project root
// Expected columns there are already shifted by the 2 and 1 cycle latencies
// Random phase keeps the strap low and checks only the output rule
////////////////////

`timescale 1ns/1ps

module io_fabric_tb;

  import pad_pkg::*;
  import jtag_pkg::*;

  ////////////////////
  // Timing and sizes
  ////////////////////

  localparam int ClkPeriod   = 40;
  localparam int DriveDelay  = 1;
  // Sample 3 ns before the next rising edge
  localparam int SampleDelay = ClkPeriod - DriveDelay - 3;
  localparam int ResetCycles = 3;
  localparam int NumRandom   = 200;
  localparam logic [31:0] Seed = 32'he5ccf8c3;

  // tck, tms, tdi low and both resets released
  localparam logic [4:0] JtagIdleBits = 5'b00011;

  // One line of the vector file
  typedef struct packed {
    pad_bus_t   pad_in;
    pad_bus_t   core_out;
    pad_bus_t   core_oe;
    pad_bus_t   pad_attr;
    logic       aes_idle;
    logic       tdo;
    pad_bus_t   exp_core_in;
    logic [4:0] exp_jtag;
    pad_bus_t   exp_pad_out;
    pad_bus_t   exp_pad_oe;
  } vector_t;

  logic        clk_main = 1'b0;
  logic        rst_n;
  pad_bus_t    pad_in;
  pad_bus_t    core_out;
  pad_bus_t    core_oe;
  pad_bus_t    pad_attr;
  logic        aes_idle;
  logic        jtag_tdo;
  pad_bus_t    pad_out;
  pad_bus_t    pad_oe;
  pad_bus_t    core_in;
  jtag_req_t   jtag;

  vector_t     vectors[$];
  logic        vectors_loaded = 1'b0;
  logic [31:0] rnd_state;

  always #(ClkPeriod / 2) clk_main = ~clk_main;

  io_fabric_top dut0 (
    .clk_main_i ( clk_main ),
    .rst_n_i    ( rst_n    ),
    .pad_in_i   ( pad_in   ),
    .pad_out_o  ( pad_out  ),
    .pad_oe_o   ( pad_oe   ),
    .core_out_i ( core_out ),
    .core_oe_i  ( core_oe  ),
    .pad_attr_i ( pad_attr ),
    .aes_idle_i ( aes_idle ),
    .core_in_o  ( core_in  ),
    .jtag_o     ( jtag     ),
    .jtag_tdo_i ( jtag_tdo )
  );

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Invert per attribute and pass the trigger only while the engine is busy
  function automatic pad_bus_t expected_pad_out(input pad_bus_t drive, input pad_bus_t attr,
                                                input logic idle);
    pad_bus_t result;
    logic     trig;
    result = drive ^ attr;
    trig   = drive.mio[MioTrigger] & ~idle;
    result.mio[MioTrigger] = trig ^ attr.mio[MioTrigger];
    return result;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
               $time, name, expected, actual);
      $display("test failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          count;
    string       line;
    logic [31:0] col [10];
    vector_t     v;
    fd = $fopen("sim/io_vectors_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the vector file sim/io_vectors_input.txt");
      $display("test failed");
      $fatal(1, "vector file missing");
    end
    while ($fgets(line, fd) != 0) begin
      // Comments and blank lines
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", col[0], col[1], col[2],
                      col[3], col[4], col[5], col[6], col[7], col[8], col[9]);
      if (count != 10) begin
        $display("Vector line has %0d columns instead of 10: %s", count, line);
        $display("test failed");
        $fatal(1, "bad vector line");
      end
      v.pad_in      = col[0][27:0];
      v.core_out    = col[1][27:0];
      v.core_oe     = col[2][27:0];
      v.pad_attr    = col[3][27:0];
      v.aes_idle    = col[4][0];
      v.tdo         = col[5][0];
      v.exp_core_in = col[6][27:0];
      v.exp_jtag    = col[7][4:0];
      v.exp_pad_out = col[8][27:0];
      v.exp_pad_oe  = col[9][27:0];
      vectors.push_back(v);
    end
    $fclose(fd);
  endtask

  task automatic apply_vector(input vector_t v);
    pad_in   = v.pad_in;
    core_out = v.core_out;
    core_oe  = v.core_oe;
    pad_attr = v.pad_attr;
    aes_idle = v.aes_idle;
    jtag_tdo = v.tdo;
  endtask

  task automatic check_vector(input vector_t v);
    check_value("core_in_o", 32'(v.exp_core_in), 32'(core_in));
    check_value("jtag_o", 32'(v.exp_jtag), 32'(jtag));
    check_value("pad_out_o", 32'(v.exp_pad_out), 32'(pad_out));
    check_value("pad_oe_o", 32'(v.exp_pad_oe), 32'(pad_oe));
  endtask

  // Strap stays low and one extra cycle flushes the last random drive
  task automatic run_random();
    pad_bus_t exp_out;
    pad_bus_t exp_oe;
    pad_bus_t next_out;
    pad_bus_t next_oe;
    // File tail keeps the strap low, so its last drive passes unchanged
    exp_out = expected_pad_out(core_out, pad_attr, aes_idle);
    exp_oe  = core_oe;
    for (int r = 0; r <= NumRandom; r++) begin
      @(posedge clk_main);
      #DriveDelay;
      pad_in   = '0;
      jtag_tdo = 1'b0;
      if (r < NumRandom) begin
        rnd_state = xorshift32(rnd_state);
        core_out  = rnd_state[27:0];
        rnd_state = xorshift32(rnd_state);
        core_oe   = rnd_state[27:0];
        rnd_state = xorshift32(rnd_state);
        pad_attr  = rnd_state[27:0];
        rnd_state = xorshift32(rnd_state);
        aes_idle  = rnd_state[0];
      end else begin
        core_out = '0;
        core_oe  = '0;
        pad_attr = '0;
        aes_idle = 1'b1;
      end
      next_out = expected_pad_out(core_out, pad_attr, aes_idle);
      next_oe  = core_oe;
      #SampleDelay;
      check_value("pad_out_o", 32'(exp_out), 32'(pad_out));
      check_value("pad_oe_o", 32'(exp_oe), 32'(pad_oe));
      check_value("jtag_o", 32'(JtagIdleBits), 32'(jtag));
      exp_out = next_out;
      exp_oe  = next_oe;
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    rst_n     = 1'b0;
    // Pads and core drive all high during reset, only the reset clears the flops
    pad_in    = '1;
    core_out  = '1;
    core_oe   = '1;
    pad_attr  = '0;
    aes_idle  = 1'b0;
    jtag_tdo  = 1'b1;
    rnd_state = Seed;
    load_vectors();
    vectors_loaded = 1'b1;

    repeat (ResetCycles) @(posedge clk_main);
    #DriveDelay;
    rst_n    = 1'b1;
    pad_in   = '0;
    core_out = '0;
    core_oe  = '0;
    aes_idle = 1'b1;
    jtag_tdo = 1'b0;

    // Reset values before the first vector
    check_value("pad_out_o", 32'h0, 32'(pad_out));
    check_value("pad_oe_o", 32'h0, 32'(pad_oe));
    check_value("jtag_o", 32'(JtagIdleBits), 32'(jtag));

    foreach (vectors[i]) begin
      @(posedge clk_main);
      #DriveDelay;
      apply_vector(vectors[i]);
      #SampleDelay;
      check_vector(vectors[i]);
    end

    run_random();

    $display("test passed");
    $finish;
  end

  ////////////////////
  // Watchdog
  ////////////////////

  initial begin
    int limit_ns;
    wait (vectors_loaded);
    limit_ns = (vectors.size() + NumRandom + 10) * ClkPeriod;
    #(limit_ns);
    $display("Timeout, the run went past %0d ns without finishing", limit_ns);
    $display("test failed");
    $fatal(1, "watchdog expired");
  end

endmodule : io_fabric_tb

// ==== sim/io_vectors_input.txt ====
# Columns: pad_in core_out core_oe pad_attr aes_idle tdo
#          exp_core_in exp_jtag exp_pad_out exp_pad_oe
# Pad buses are 7 hex digits, dio in the top byte, mio in the low 20 bits
# exp_core_in and exp_jtag follow pad_in from 2 lines earlier
# exp_pad_out and exp_pad_oe follow the drive from 1 line earlier
# exp_jtag bits are tck tms tdi trst_n srst_n, idle is 03
#
# Strap low, pads pass through, trigger gating and inversion
0123456 00000FF 00000FF 0000000 1 0 0000000 03 0000000 0000000
A5A5A5A 0F0F0F0 FFFFFFF 0000F00 1 1 0000000 03 00000FF 00000FF
5A4A5A5 0008000 0008000 0000000 1 0 0123456 03 0F07FF0 FFFFFFF
0F00000 0008000 0008000 0000000 0 0 A5A5A5A 03 0000000 0008000
00C0000 0008000 0008000 0008000 1 0 5A4A5A5 03 0008000 0008000
1264568 0008000 0008000 0008000 0 0 0F00000 03 0008000 0008000
0000000 FFFFFFF 0F00000 FFFFFFF 0 0 00C0000 03 0000000 0008000
0000000 1234567 7654321 0000000 1 0 1264568 03 0000000 0F00000
#
# Strap high, JTAG pins toggle, core sees the tie-off, SDO carries tdo
0010000 0000000 0000000 0000000 1 1 0000000 03 1234567 7654321
0150000 FFFFFFF FFFFFFF 0000000 1 0 0000000 03 0000000 0000000
0290000 0000000 0000000 0000000 1 1 0210000 00 FFF7FFF FFFFFFF
0CD0000 00000F7 0F000FF 0000000 1 1 0210000 12 0800000 0800000
FFFFFFF 0F00000 0000000 0F00000 0 0 0210000 09 08000F7 08000FF
8BB2345 0A0A0A0 0A0A0A0 0505050 1 1 0A10000 07 0800000 0800000
0710000 0000000 0000000 0000000 1 0 FA3FFFF 1F 0F070F0 080A0A0
0010000 0008000 0008000 0000000 0 1 8A32345 19 0000000 0800000
#
# Strap drops, pipeline drains back to pass-through
0000000 0000000 0000000 0000000 1 1 0210000 1C 0808000 0808000
0000000 0F00000 0F00000 0000000 1 0 0210000 00 0800000 0800000
0F00000 0F00000 0F00000 0000000 1 1 0000000 03 0700000 0800000
1224567 0000000 0000000 0000000 1 0 0000000 03 0F00000 0F00000
0000000 0000000 0000000 0000000 1 0 0F00000 03 0000000 0000000
0000000 0000000 0000000 0000000 1 0 1224567 03 0000000 0000000

// ==== tb.f ====
src/pad_pkg.sv
src/jtag_pkg.sv
src/pad_in_sync.sv
src/jtag_overlay_mux.sv
src/pad_out_stage.sv
src/io_fabric_top.sv
sim/io_fabric_tb.sv

// ==== Makefile ====
# Verilator build and run of the pad fabric testbench

TOP := io_fabric_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and check sim.log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing -sv -f tb.f --top-module $(TOP) \
		-Mdir obj_dir -o sim_$(TOP)
	-./obj_dir/sim_$(TOP) > sim.log 2>&1
	@cat sim.log
	@grep -qx "test passed" sim.log || (echo "Simulation did not pass, see sim.log" && exit 1)

clean:
	rm -rf obj_dir sim.log
